//--- compile.f
+incdir+logic
logic/sched_cmd_pkg.sv
logic/sched_bus_pkg.sv
logic/cmd_fifo.sv
logic/sched_timer.sv
logic/sched_ctrl_regs.sv
logic/cmd_scheduler.sv
logic/sched_top.sv
tests/sched_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= sched_tb
BUILD_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/sched_macros.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/sched_tb.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module sched_tb
	import sched_cmd_pkg::*;
	import sched_bus_pkg::*;
();
	logic clk = 1'b0;
	logic rst = 1'b1;
	logic push = 1'b0;
	sched_cmd_t cmd_in = '0;
	reg_req_t reg_req = '0;
	logic [31:0] reg_rdata;
	cmd_bus_t cmd_bus;
	logic [31:0] current_time;

	// commands pushed and not yet seen on the bus or the timer
	sched_cmd_t model[$];
	sched_cmd_t head;
	logic [31:0] prev_time = '0;
	logic [31:0] rdata;
	logic [31:0] t0;
	logic burst = 1'b0;
	int checks = 0;
	int errors = 0;
	int bus_count = 0;
	int cycle = 0;
	int last_issue = -1;
	int b0;
	int start;
	int i;

	sched_top UUT (.clk(clk), .rst(rst), .push(push), .cmd_in(cmd_in), .reg_req(reg_req),
		.reg_rdata(reg_rdata), .cmd_bus(cmd_bus), .current_time(current_time));

	always #4 clk = ~clk;

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic push_cmd(input sched_cmd_t c, input logic accepted);
		@(negedge clk);
		push = 1'b1;
		cmd_in = c;
		if (accepted)
			model.push_back(c);
		@(negedge clk);
		push = 1'b0;
	endtask

	task automatic access_reg(input logic is_write, input logic [1:0] reg_addr,
			input logic [31:0] wdata_in);
		@(negedge clk);
		reg_req = '{wr: is_write, addr: reg_addr, wdata: wdata_in};
		@(posedge clk);
		rdata = reg_rdata;
		@(negedge clk);
		reg_req.wr = 1'b0;
	endtask

	task automatic wait_level(input int max_left, input int limit);
		int n;
		n = 0;
		while (model.size() > max_left && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (model.size() > max_left) begin
			errors++;
			$display("timeout after %0d cycles, %0d commands still pending", limit, model.size());
		end
	endtask

	function automatic sched_cmd_t make_cmd(input logic allow_timer, input logic zero_stamp);
		sched_cmd_t c;
		logic timer_busy;
		timer_busy = 1'b0;
		foreach (model[k])
			if (model[k].addr == `SCHED_TIMER_ADDR)
				timer_busy = 1'b1;
		c.addr = 16'($urandom % 32'hFFFF);
		c.payload.data = $urandom;
		c.stamp = current_time + 32'd1 + ($urandom % 32'd40);
		if (zero_stamp || ($urandom % 32'd4) == 32'd0)
			c.stamp = '0;
		// one timer command in flight keeps every jump forward
		if (allow_timer && !timer_busy && ($urandom % 32'd8) == 32'd0) begin
			c.addr = `SCHED_TIMER_ADDR;
			c.payload.load = current_time + 32'h0100_0000 + ($urandom % 32'h0100_0000);
		end
		return c;
	endfunction

	always @(posedge clk) begin
		if (!rst) begin
			cycle++;
			check_eq("cmd_bus.wr", 32'(cmd_bus.en), 32'(cmd_bus.wr));
			if (cmd_bus.en) begin
				if (model.size() == 0 || model[0].addr == `SCHED_TIMER_ADDR) begin
					errors++;
					$display("bus write at %0t ns matches no pending bus command", $time);
				end else begin
					head = model.pop_front();
					check_eq("cmd_bus.addr", 32'(head.addr), 32'(cmd_bus.addr));
					check_eq("cmd_bus.data", head.payload.data, cmd_bus.data);
					if (head.stamp != 0 && current_time < head.stamp) begin
						errors++;
						$display("command issued at time %0d before its stamp %0d",
							current_time, head.stamp);
					end
					// due commands leave every 3 cycles
					if (burst && last_issue >= 0 && cycle - last_issue > 3) begin
						errors++;
						$display("gap of %0d cycles between due commands", cycle - last_issue);
					end
					last_issue = cycle;
					bus_count++;
				end
			end
			// anything but hold or +1 is a timer load
			if (current_time != prev_time && current_time != prev_time + 32'd1) begin
				if (model.size() == 0 || model[0].addr != `SCHED_TIMER_ADDR) begin
					errors++;
					$display("current_time jumped at %0t ns without a timer command", $time);
				end else begin
					head = model.pop_front();
					check_eq("current_time", head.payload.load, current_time);
				end
			end
			prev_time = current_time;
		end
	end

	initial begin
		void'($urandom(32));
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// random traffic with timer commands mixed in
		start = errors;
		access_reg(1'b1, `REG_CTRL, 32'h1);
		for (i = 0; i < 48; i++) begin
			wait_level(11, 1000);
			repeat ($urandom % 32'd4) @(negedge clk);
			push_cmd(make_cmd(1'b1, 1'b0), 1'b1);
		end
		wait_level(0, 5000);
		$display("test random_traffic: %0d errors", errors - start);

		// stop and restart
		start = errors;
		access_reg(1'b1, `REG_CTRL, 32'h0);
		repeat (4) @(negedge clk);
		t0 = current_time;
		b0 = bus_count;
		for (i = 0; i < 4; i++)
			push_cmd(make_cmd(1'b0, 1'b1), 1'b1);
		repeat (30) @(negedge clk);
		check_eq("current_time", t0, current_time);
		check_eq("bus write count", 32'(b0), 32'(bus_count));
		access_reg(1'b0, `REG_TIME, 32'h0);
		check_eq("time register", t0, rdata);
		access_reg(1'b0, `REG_CTRL, 32'h0);
		check_eq("ctrl.run_en", 32'd0, 32'(rdata[0]));
		access_reg(1'b1, `REG_CTRL, 32'h1);
		wait_level(0, 2000);
		$display("test run_enable: %0d errors", errors - start);

		// overflow and then a burst of due commands
		start = errors;
		access_reg(1'b1, `REG_CTRL, 32'h0);
		for (i = 0; i < 20; i++)
			push_cmd(make_cmd(1'b0, 1'b1), i < `SCHED_FIFO_DEPTH);
		access_reg(1'b0, `REG_STATUS, 32'h0);
		check_eq("status.level", 32'd16, 32'(rdata[4:0]));
		check_eq("status.overflow", 32'd1, 32'(rdata[8]));
		access_reg(1'b1, `REG_CTRL, 32'h2);
		access_reg(1'b0, `REG_STATUS, 32'h0);
		check_eq("status.overflow", 32'd0, 32'(rdata[8]));
		burst = 1'b1;
		last_issue = -1;
		access_reg(1'b1, `REG_CTRL, 32'h1);
		wait_level(0, 200);
		burst = 1'b0;
		access_reg(1'b0, `REG_ISSUED, 32'h0);
		check_eq("issued", 32'(bus_count), rdata);
		$display("test overflow_status: %0d errors", errors - start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- logic/sched_top.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module sched_top
	import sched_cmd_pkg::*;
	import sched_bus_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  sched_cmd_t cmd_in,
	input  reg_req_t reg_req,
	output logic [`SCHED_DATA_W-1:0] reg_rdata,
	output cmd_bus_t cmd_bus,
	output logic [`SCHED_TIME_W-1:0] current_time
);
	sched_cmd_t fifo_dout;
	logic fifo_valid;
	logic fifo_empty;
	logic fifo_rd_en;
	logic [`SCHED_LEVEL_W-1:0] level;
	logic overflow;
	logic run_en;
	logic time_load;
	timer_load_t load_value;
	logic issue;

	cmd_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.din(cmd_in),
		.rd_en(fifo_rd_en),
		.dout(fifo_dout),
		.dout_valid(fifo_valid),
		.empty(fifo_empty),
		.level(level),
		.overflow(overflow)
	);

	sched_timer u_timer (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.load(time_load),
		.load_value(load_value),
		.current_time(current_time)
	);

	sched_ctrl_regs u_regs (
		.clk(clk),
		.rst(rst),
		.reg_req(reg_req),
		.reg_rdata(reg_rdata),
		.run_en(run_en),
		.issue(issue),
		.overflow_pulse(overflow),
		.level(level),
		.current_time(current_time)
	);

	cmd_scheduler u_sched (
		.clk(clk),
		.rst(rst),
		.run_en(run_en),
		.current_time(current_time),
		.fifo_dout(fifo_dout),
		.fifo_valid(fifo_valid),
		.fifo_empty(fifo_empty),
		.fifo_rd_en(fifo_rd_en),
		.cmd_bus(cmd_bus),
		.time_load(time_load),
		.load_value(load_value),
		.issue(issue)
	);

endmodule

//--- logic/cmd_scheduler.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module cmd_scheduler
	import sched_cmd_pkg::*;
	import sched_bus_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic run_en,
	input  logic [`SCHED_TIME_W-1:0] current_time,
	input  sched_cmd_t fifo_dout,
	input  logic fifo_valid,
	input  logic fifo_empty,
	output logic fifo_rd_en,
	output cmd_bus_t cmd_bus,
	output logic time_load,
	output timer_load_t load_value,
	output logic issue
);
	// one-hot states
	localparam logic [2:0] ST_FETCH = 3'b001;
	localparam logic [2:0] ST_WAIT = 3'b010;
	localparam logic [2:0] ST_EXEC = 3'b100;

	logic [2:0] state;
	logic [2:0] state_next;
	sched_cmd_t cmd_q;
	logic due;
	logic is_timer;
	logic fire;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= ST_FETCH;
		else
			state <= state_next;
	end

	// held command
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && fifo_valid)
			cmd_q <= fifo_dout;
	end

	// zero stamp means issue at once
	assign due = (cmd_q.stamp == '0) || (current_time >= cmd_q.stamp);
	assign is_timer = (cmd_q.addr == `SCHED_TIMER_ADDR);
	assign fire = (state == ST_EXEC) && due;

	always_comb begin
		state_next = state;
		fifo_rd_en = 1'b0;
		case (state)
			ST_FETCH: begin
				// no new fetch while stopped
				if (!fifo_empty && run_en) begin
					fifo_rd_en = 1'b1;
					state_next = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (fifo_valid)
					state_next = ST_EXEC;
			end
			ST_EXEC: begin
				if (due)
					state_next = ST_FETCH;
			end
			default: state_next = ST_FETCH;
		endcase
	end

	// payload read as bus data or as timer value depending on address
	assign cmd_bus.addr = cmd_q.addr;
	assign cmd_bus.data = cmd_q.payload.data;
	assign cmd_bus.en = fire && !is_timer;
	assign cmd_bus.wr = fire && !is_timer;
	assign time_load = fire && is_timer;
	assign load_value = cmd_q.payload.load;
	assign issue = cmd_bus.en;

	a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));
	a_bus_xor_load: assert property (
		@(posedge clk) disable iff (rst) !(cmd_bus.en && time_load)
	);
	a_bus_in_exec: assert property (
		@(posedge clk) disable iff (rst) cmd_bus.en |-> (state == ST_EXEC)
	);

endmodule

//--- logic/sched_ctrl_regs.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module sched_ctrl_regs
	import sched_bus_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  reg_req_t reg_req,
	output logic [`SCHED_DATA_W-1:0] reg_rdata,
	output logic run_en,
	input  logic issue,
	input  logic overflow_pulse,
	input  logic [`SCHED_LEVEL_W-1:0] level,
	input  logic [`SCHED_TIME_W-1:0] current_time
);
	logic overflow_flag;
	logic [`SCHED_DATA_W-1:0] issued_cnt;
	logic ctrl_wr;

	assign ctrl_wr = reg_req.wr && (reg_req.addr == `REG_CTRL);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			run_en <= 1'b0;
			overflow_flag <= 1'b0;
			issued_cnt <= '0;
		end else begin
			if (ctrl_wr)
				run_en <= reg_req.wdata[0];
			// a new overflow beats a clear in the same cycle
			if (overflow_pulse)
				overflow_flag <= 1'b1;
			else if (ctrl_wr && reg_req.wdata[1])
				overflow_flag <= 1'b0;
			if (issue)
				issued_cnt <= issued_cnt + 1'b1;
		end
	end

	// read mux
	always_comb begin
		reg_rdata = '0;
		case (reg_req.addr)
			`REG_CTRL: reg_rdata[0] = run_en;
			`REG_STATUS: begin
				reg_rdata[`SCHED_LEVEL_W-1:0] = level;
				reg_rdata[8] = overflow_flag;
			end
			`REG_ISSUED: reg_rdata = issued_cnt;
			`REG_TIME: reg_rdata = current_time;
			default: reg_rdata = '0;
		endcase
	end

endmodule

//--- logic/sched_timer.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module sched_timer
	import sched_cmd_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic run_en,
	input  logic load,
	input  timer_load_t load_value,
	output logic [`SCHED_TIME_W-1:0] current_time
);

	// load wins over counting and counting resumes from the new value
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			current_time <= '0;
		else if (load)
			current_time <= load_value;
		else if (run_en)
			current_time <= current_time + 1'b1;
	end

endmodule

//--- logic/cmd_fifo.sv
`timescale 1ns/1ns
`include "sched_macros.svh"

module cmd_fifo
	import sched_cmd_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  sched_cmd_t din,
	input  logic rd_en,
	output sched_cmd_t dout,
	output logic dout_valid,
	output logic empty,
	output logic [`SCHED_LEVEL_W-1:0] level,
	output logic overflow
);
	localparam int DEPTH = `SCHED_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sched_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (level == `SCHED_LEVEL_W'(DEPTH));
	assign empty = (level == '0);
	assign do_push = push && !full;
	assign do_pop = rd_en && !empty;

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
		if (do_pop)
			dout <= mem[rd_ptr];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			dout_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			dout_valid <= do_pop;
			// pushes into a full queue are lost
			overflow <= push && full;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				level <= level + 1'b1;
			else if (do_pop && !do_push)
				level <= level - 1'b1;
		end
	end

	// the scheduler only fetches from a non-empty queue
	a_no_read_empty: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

//--- logic/sched_bus_pkg.sv
`include "sched_macros.svh"

package sched_bus_pkg;

	// write-only command bus towards the peripherals
	typedef struct packed {
		logic [`SCHED_ADDR_W-1:0] addr;
		logic [`SCHED_DATA_W-1:0] data;
		logic en;
		logic wr;
	} cmd_bus_t;

	// single-cycle host register access
	typedef struct packed {
		logic wr;
		logic [`SCHED_REG_ADDR_W-1:0] addr;
		logic [`SCHED_DATA_W-1:0] wdata;
	} reg_req_t;

endpackage

//--- logic/sched_cmd_pkg.sv
`include "sched_macros.svh"

package sched_cmd_pkg;

	// new timer value carried by a timer command
	typedef logic [`SCHED_TIME_W-1:0] timer_load_t;

	// the middle 32 bits of a command
	// plain bus data for normal addresses, timer value for the timer address
	typedef union packed {
		logic [`SCHED_DATA_W-1:0] data;
		timer_load_t load;
	} cmd_payload_u;

	// 80-bit queue word, stamp in the top bits
	typedef struct packed {
		logic [`SCHED_TIME_W-1:0] stamp;
		cmd_payload_u payload;
		logic [`SCHED_ADDR_W-1:0] addr;
	} sched_cmd_t;

endpackage

//--- logic/sched_macros.svh
`ifndef SCHED_MACROS_SVH
`define SCHED_MACROS_SVH

// command word field widths
`define SCHED_TIME_W 32
`define SCHED_ADDR_W 16
`define SCHED_DATA_W 32

// queue depth, must stay a power of two
`define SCHED_FIFO_DEPTH 16
`define SCHED_LEVEL_W ($clog2(`SCHED_FIFO_DEPTH) + 1)

// bus address that reloads the timer instead of going out
`define SCHED_TIMER_ADDR 16'hFFFF

// host register map
`define SCHED_REG_ADDR_W 2
`define REG_CTRL 2'd0
`define REG_STATUS 2'd1
`define REG_ISSUED 2'd2
`define REG_TIME 2'd3

`endif
